/* ncpu_idu.f */
+incdir+.
ncpu_idu_pkg.sv
ncpu_idu_decoder.sv
ncpu_idu_operand_sel.sv
ncpu_idu_stage.sv
ncpu_idu.sv
tb_ncpu_idu.sv

/* ncpu_idu.sv */
// Decode stage top level
//   decoder, operand select and the one-entry command stage
`timescale 1ns/10ps
`default_nettype none

module ncpu_idu (
   input  logic                                 clk,
   input  logic                                 rst_i,
   input  logic                                 idu_valid_i,
   output logic                                 idu_ready_o,
   input  logic [ncpu_idu_pkg::NCPU_IW-1:0]     insn_i,
   input  logic                                 flush_i,
   output logic                                 regf_rs1_re_o,
   output logic [ncpu_idu_pkg::NCPU_REG_AW-1:0] regf_rs1_addr_o,
   input  logic [ncpu_idu_pkg::NCPU_DW-1:0]     regf_rs1_dout_i,
   output logic                                 regf_rs2_re_o,
   output logic [ncpu_idu_pkg::NCPU_REG_AW-1:0] regf_rs2_addr_o,
   input  logic [ncpu_idu_pkg::NCPU_DW-1:0]     regf_rs2_dout_i,
   output logic                                 ieu_valid_o,
   input  logic                                 ieu_ready_i,
   output ncpu_idu_pkg::ieu_cmd_t               ieu_cmd_o,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     ieu_operand_1_o,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     ieu_operand_2_o,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     ieu_operand_3_o
);
   import ncpu_idu_pkg::*;

   ieu_cmd_t dec_cmd;
   opsrc_t   dec_opsrc;
   logic     dec_imm14_signed;
   logic     dec_imm18_sel;
   logic     dec_non_op;
   logic     cas;

   // The imm14 form flag is only needed inside the decoder
   ncpu_idu_decoder u_decoder (
      .insn_i         (insn_i),
      .cmd_o          (dec_cmd),
      .opsrc_o        (dec_opsrc),
      .imm14_o        (),
      .imm14_signed_o (dec_imm14_signed),
      .imm18_sel_o    (dec_imm18_sel),
      .non_op_o       (dec_non_op)
   );

   ncpu_idu_operand_sel u_operand_sel (
      .clk             (clk),
      .rst_i           (rst_i),
      .cas_i           (cas),
      .insn_i          (insn_i),
      .opsrc_i         (dec_opsrc),
      .imm14_signed_i  (dec_imm14_signed),
      .imm18_sel_i     (dec_imm18_sel),
      .non_op_i        (dec_non_op),
      .regf_rs1_re_o   (regf_rs1_re_o),
      .regf_rs1_addr_o (regf_rs1_addr_o),
      .regf_rs2_re_o   (regf_rs2_re_o),
      .regf_rs2_addr_o (regf_rs2_addr_o),
      .regf_rs1_dout_i (regf_rs1_dout_i),
      .regf_rs2_dout_i (regf_rs2_dout_i),
      .operand_1_o     (ieu_operand_1_o),
      .operand_2_o     (ieu_operand_2_o),
      .operand_3_o     (ieu_operand_3_o)
   );

   ncpu_idu_stage u_stage (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_valid_i  (idu_valid_i),
      .in_ready_o  (idu_ready_o),
      .cas_o       (cas),
      .cmd_i       (dec_cmd),
      .flush_i     (flush_i),
      .out_valid_o (ieu_valid_o),
      .out_ready_i (ieu_ready_i),
      .cmd_o       (ieu_cmd_o)
   );

endmodule

`default_nettype wire

/* ncpu_idu_decoder.sv */
// Opcode decoder of the decode stage
//   one-hot logic and arithmetic unit operations, compare attributes
//   memory control with access sizes and sign extension
//   immediate form flags and operand source flags
`timescale 1ns/10ps
`default_nettype none

module ncpu_idu_decoder (
   input  logic [ncpu_idu_pkg::NCPU_IW-1:0] insn_i,
   output ncpu_idu_pkg::ieu_cmd_t           cmd_o,
   output ncpu_idu_pkg::opsrc_t             opsrc_o,
   output logic                             imm14_o,
   output logic                             imm14_signed_o,
   output logic                             imm18_sel_o,
   output logic                             non_op_o
);
   import ncpu_idu_pkg::*;

   logic [5:0] opc;
   logic [7:0] attr;
   lu_opc_t    lu;
   au_opc_t    au;
   mu_ctrl_t   mu;
   logic       emu;

   assign opc  = insn_i[OPC_MSB:OPC_LSB];
   assign attr = insn_i[ATTR_MSB:ATTR_LSB];

   always_comb begin
      lu             = '0;
      au             = '0;
      mu             = '0;
      emu            = 1'b0;
      imm14_o        = 1'b0;
      imm14_signed_o = 1'b0;
      imm18_sel_o    = 1'b0;
      non_op_o       = 1'b0;
      case (opc)
         OP_AND:   lu.op_and = 1'b1;
         OP_OR:    lu.op_or  = 1'b1;
         OP_XOR:   lu.op_xor = 1'b1;
         OP_LSL:   lu.op_lsl = 1'b1;
         OP_LSR:   lu.op_lsr = 1'b1;
         OP_ASR:   lu.op_asr = 1'b1;
         OP_AND_I: begin lu.op_and = 1'b1; imm14_o = 1'b1; imm14_signed_o = 1'b1; end
         OP_XOR_I: begin lu.op_xor = 1'b1; imm14_o = 1'b1; imm14_signed_o = 1'b1; end
         OP_OR_I:  begin lu.op_or  = 1'b1; imm14_o = 1'b1; end
         OP_LSL_I: begin lu.op_lsl = 1'b1; imm14_o = 1'b1; end
         OP_LSR_I: begin lu.op_lsr = 1'b1; imm14_o = 1'b1; end
         OP_ASR_I: begin lu.op_asr = 1'b1; imm14_o = 1'b1; end
         OP_CMP: begin
            au.op_cmp     = 1'b1;
            au.cmp_eq     = (attr == ATTR_EQ);
            au.cmp_signed = (attr == ATTR_GT);
         end
         OP_ADD:   au.op_add = 1'b1;
         OP_ADD_I: begin au.op_add = 1'b1; imm14_o = 1'b1; imm14_signed_o = 1'b1; end
         OP_SUB:   au.op_sub = 1'b1;
         OP_MHI:   begin au.op_mhi = 1'b1; imm18_sel_o = 1'b1; end
         // Loads and stores address with rs1 plus signed imm14
         OP_LDB:   begin mu.load = 1'b1; mu.load_size = SIZE_B; mu.sign_ext = 1'b1; end
         OP_LDBU:  begin mu.load = 1'b1; mu.load_size = SIZE_B; end
         OP_LDH:   begin mu.load = 1'b1; mu.load_size = SIZE_H; mu.sign_ext = 1'b1; end
         OP_LDHU:  begin mu.load = 1'b1; mu.load_size = SIZE_H; end
         OP_LDWU:  begin mu.load = 1'b1; mu.load_size = SIZE_W; end
         OP_STB:   begin mu.store = 1'b1; mu.store_size = SIZE_B; end
         OP_STH:   begin mu.store = 1'b1; mu.store_size = SIZE_H; end
         OP_STW:   begin mu.store = 1'b1; mu.store_size = SIZE_W; end
         OP_MBARR: begin mu.barr = 1'b1; non_op_o = 1'b1; end
         default:  emu = 1'b1;
      endcase
      if (mu.load | mu.store) begin
         imm14_o        = 1'b1;
         imm14_signed_o = 1'b1;
      end
   end

   always_comb begin
      cmd_o             = '0;
      cmd_o.lu          = lu;
      cmd_o.au          = au;
      cmd_o.mu          = mu;
      cmd_o.emu_insn    = emu;
      cmd_o.wb_regf     = ~(mu.barr | au.op_cmp | mu.store | emu);
      cmd_o.wb_reg_addr = insn_i[RD_LSB +: NCPU_REG_AW];
   end

   // mhi takes imm18 on both operands, so rs1 is not needed there
   assign opsrc_o.rs1_from_regf = ~non_op_o & ~imm18_sel_o;
   assign opsrc_o.rs2_from_regf = ~non_op_o & ~imm14_o & ~imm18_sel_o;
   assign opsrc_o.rd_as_rs2     = mu.store;

   always_comb begin
      if (!$isunknown(insn_i)) begin
         assert (!(mu.load && mu.store))
            else $error("decoder: load and store decoded together");
      end
   end

endmodule

`default_nettype wire

/* ncpu_idu_operand_sel.sv */
// Operand selection of the decode stage
//   register file read requests, rd read through the rs2 port for stores
//   sign or zero extended immediate, held with the source flags
//   final operand muxes for the execute unit
`timescale 1ns/10ps
`default_nettype none

module ncpu_idu_operand_sel (
   input  logic                                 clk,
   input  logic                                 rst_i,
   input  logic                                 cas_i,
   input  logic [ncpu_idu_pkg::NCPU_IW-1:0]     insn_i,
   input  ncpu_idu_pkg::opsrc_t                 opsrc_i,
   input  logic                                 imm14_signed_i,
   input  logic                                 imm18_sel_i,
   input  logic                                 non_op_i,
   output logic                                 regf_rs1_re_o,
   output logic [ncpu_idu_pkg::NCPU_REG_AW-1:0] regf_rs1_addr_o,
   output logic                                 regf_rs2_re_o,
   output logic [ncpu_idu_pkg::NCPU_REG_AW-1:0] regf_rs2_addr_o,
   input  logic [ncpu_idu_pkg::NCPU_DW-1:0]     regf_rs1_dout_i,
   input  logic [ncpu_idu_pkg::NCPU_DW-1:0]     regf_rs2_dout_i,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     operand_1_o,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     operand_2_o,
   output logic [ncpu_idu_pkg::NCPU_DW-1:0]     operand_3_o
);
   import ncpu_idu_pkg::*;

   logic [13:0]        imm14;
   logic [17:0]        imm18;
   logic [NCPU_DW-1:0] imm_ext;
   logic [NCPU_DW-1:0] imm_nxt;
   logic [NCPU_DW-1:0] imm_r;
   opsrc_t             src_r;

   // Read requests go out only in the accept cycle
   assign regf_rs1_re_o   = cas_i & opsrc_i.rs1_from_regf;
   assign regf_rs1_addr_o = insn_i[RS1_LSB +: NCPU_REG_AW];
   assign regf_rs2_re_o   = cas_i & (opsrc_i.rs2_from_regf | opsrc_i.rd_as_rs2);
   assign regf_rs2_addr_o = opsrc_i.rd_as_rs2 ? insn_i[RD_LSB +: NCPU_REG_AW]
                                              : insn_i[RS2_LSB +: NCPU_REG_AW];

   assign imm14 = insn_i[IMM14_MSB:IMM14_LSB];
   assign imm18 = insn_i[IMM18_MSB:IMM18_LSB];

   always_comb begin
      if (imm18_sel_i) begin
         imm_ext = {{(NCPU_DW-18){1'b0}}, imm18};
      end else if (imm14_signed_i) begin
         imm_ext = {{(NCPU_DW-14){imm14[13]}}, imm14};
      end else begin
         imm_ext = {{(NCPU_DW-14){1'b0}}, imm14};
      end
   end

   // mbarr carries no operand at all
   assign imm_nxt = non_op_i ? '0 : imm_ext;

   always_ff @(posedge clk) begin
      if (cas_i) begin
         imm_r <= imm_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         src_r <= '0;
      end else if (cas_i) begin
         src_r <= opsrc_i;
      end
   end

   // Register file holds its data until the next read, so these stay valid
   assign operand_1_o = src_r.rs1_from_regf ? regf_rs1_dout_i : imm_r;
   assign operand_2_o = src_r.rs2_from_regf ? regf_rs2_dout_i : imm_r;
   assign operand_3_o = src_r.rd_as_rs2 ? regf_rs2_dout_i : '0;

   a_read_only_on_cas: assert property (
      @(posedge clk) disable iff (rst_i)
      (regf_rs1_re_o || regf_rs2_re_o) |-> cas_i);

endmodule

`default_nettype wire

/* ncpu_idu_pkg.sv */
// Shared definitions for the decode stage
//   data, instruction and register address widths
//   instruction field positions and compare attributes
//   opcode enum and memory access size enum
//   unit operation, memory control, execute command and operand source structs
`default_nettype none

package ncpu_idu_pkg;

   localparam int NCPU_DW     = 32;
   localparam int NCPU_IW     = 32;
   localparam int NCPU_REG_AW = 5;

   // Instruction fields
   localparam int OPC_MSB   = 5;
   localparam int OPC_LSB   = 0;
   localparam int RD_MSB    = 11;
   localparam int RD_LSB    = 6;
   localparam int RS1_MSB   = 17;
   localparam int RS1_LSB   = 12;
   localparam int RS2_MSB   = 23;
   localparam int RS2_LSB   = 18;
   localparam int ATTR_MSB  = 31;
   localparam int ATTR_LSB  = 24;
   localparam int IMM14_MSB = 31;
   localparam int IMM14_LSB = 18;
   localparam int IMM18_MSB = 29;
   localparam int IMM18_LSB = 12;

   // Compare attributes
   localparam logic [7:0] ATTR_EQ = 8'h01;
   localparam logic [7:0] ATTR_GT = 8'h02;

   typedef enum logic [2:0] {
      SIZE_NONE = 3'd0,
      SIZE_B    = 3'd1,
      SIZE_H    = 3'd2,
      SIZE_W    = 3'd3
   } mem_size_e;

   // Opcodes not listed here are emulated
   typedef enum logic [5:0] {
      OP_AND   = 6'h01,
      OP_AND_I = 6'h02,
      OP_OR    = 6'h03,
      OP_OR_I  = 6'h04,
      OP_XOR   = 6'h05,
      OP_XOR_I = 6'h06,
      OP_LSL   = 6'h07,
      OP_LSL_I = 6'h08,
      OP_LSR   = 6'h09,
      OP_LSR_I = 6'h0a,
      OP_ASR   = 6'h0b,
      OP_ASR_I = 6'h0c,
      OP_CMP   = 6'h0d,
      OP_ADD   = 6'h0e,
      OP_ADD_I = 6'h0f,
      OP_SUB   = 6'h10,
      OP_MHI   = 6'h11,
      OP_LDB   = 6'h12,
      OP_LDBU  = 6'h13,
      OP_LDH   = 6'h14,
      OP_LDHU  = 6'h15,
      OP_LDWU  = 6'h16,
      OP_STB   = 6'h17,
      OP_STH   = 6'h18,
      OP_STW   = 6'h19,
      OP_MBARR = 6'h1a
   } opcode_e;

   typedef struct packed {
      logic op_and;
      logic op_or;
      logic op_xor;
      logic op_lsl;
      logic op_lsr;
      logic op_asr;
   } lu_opc_t;

   // One-hot ops plus the two compare qualifiers
   typedef struct packed {
      logic op_cmp;
      logic op_add;
      logic op_sub;
      logic op_mhi;
      logic cmp_eq;
      logic cmp_signed;
   } au_opc_t;

   typedef struct packed {
      logic      load;
      logic      store;
      logic      barr;
      logic      sign_ext;
      mem_size_e load_size;
      mem_size_e store_size;
   } mu_ctrl_t;

   typedef struct packed {
      lu_opc_t                lu;
      au_opc_t                au;
      mu_ctrl_t               mu;
      logic                   emu_insn;
      logic                   wb_regf;
      logic [NCPU_REG_AW-1:0] wb_reg_addr;
   } ieu_cmd_t;

   typedef struct packed {
      logic rs1_from_regf;
      logic rs2_from_regf;
      logic rd_as_rs2;
   } opsrc_t;

endpackage

`default_nettype wire

/* ncpu_idu_stage.sv */
// One-entry valid/ready stage holding the execute command
//   full throughput, accepts while the held item leaves
//   speculative flush clears the control bits of the captured command
`timescale 1ns/10ps
`default_nettype none

module ncpu_idu_stage (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   in_valid_i,
   output logic                   in_ready_o,
   output logic                   cas_o,
   input  ncpu_idu_pkg::ieu_cmd_t cmd_i,
   input  logic                   flush_i,
   output logic                   out_valid_o,
   input  logic                   out_ready_i,
   output ncpu_idu_pkg::ieu_cmd_t cmd_o
);
   import ncpu_idu_pkg::*;

   logic     valid_r;
   ieu_cmd_t cmd_r;
   ieu_cmd_t cmd_gated;

   assign in_ready_o = ~valid_r | out_ready_i;
   assign cas_o      = in_valid_i & in_ready_o;

   // Data fields pass untouched on a flush
   always_comb begin
      cmd_gated = cmd_i;
      if (flush_i) begin
         cmd_gated.emu_insn    = 1'b0;
         cmd_gated.wb_regf     = 1'b0;
         cmd_gated.mu.load     = 1'b0;
         cmd_gated.mu.store    = 1'b0;
         cmd_gated.mu.barr     = 1'b0;
         cmd_gated.mu.sign_ext = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_r            <= 1'b0;
         cmd_r.emu_insn     <= 1'b0;
         cmd_r.wb_regf      <= 1'b0;
         cmd_r.mu.load      <= 1'b0;
         cmd_r.mu.store     <= 1'b0;
         cmd_r.mu.barr      <= 1'b0;
         cmd_r.mu.sign_ext  <= 1'b0;
      end else if (cas_o) begin
         valid_r <= 1'b1;
         cmd_r   <= cmd_gated;
      end else if (out_ready_i) begin
         valid_r <= 1'b0;
      end
   end

   assign out_valid_o = valid_r;
   assign cmd_o       = cmd_r;

   a_hold_on_stall: assert property (
      @(posedge clk) disable iff (rst_i)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(cmd_o)));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ncpu_idu.f --top-module tb_ncpu_idu \
   -o sim_tb_ncpu_idu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb_ncpu_idu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
   exit 0
fi
exit 1

/* tb_ncpu_idu_ref.svh */
// Reference model for the decode stage testbench
//   register file contents as a function of the register number
//   expected execute command, operands, read enables and read addresses
`ifndef TB_NCPU_IDU_REF_SVH
`define TB_NCPU_IDU_REF_SVH

typedef struct packed {
   ieu_cmd_t               cmd;
   logic [NCPU_DW-1:0]     op1;
   logic [NCPU_DW-1:0]     op2;
   logic [NCPU_DW-1:0]     op3;
   logic                   rs1_re;
   logic                   rs2_re;
   logic [NCPU_REG_AW-1:0] rs1_addr;
   logic [NCPU_REG_AW-1:0] rs2_addr;
} exp_item_t;

function automatic logic [NCPU_DW-1:0] reg_value(input logic [NCPU_REG_AW-1:0] r);
   return ({{(NCPU_DW-NCPU_REG_AW){1'b0}}, r} * 32'h01010101) ^ 32'h5a5a0000;
endfunction

function automatic exp_item_t expected_item(input logic [NCPU_IW-1:0] insn, input logic flush);
   exp_item_t          e;
   logic [5:0]         op;
   logic               imm_s;
   logic               imm_u;
   logic               no_rs1;
   logic [NCPU_DW-1:0] sx14;
   logic [NCPU_DW-1:0] zx14;
   logic [NCPU_DW-1:0] zx18;
   op   = insn[OPC_MSB:OPC_LSB];
   sx14 = {{18{insn[IMM14_MSB]}}, insn[IMM14_MSB:IMM14_LSB]};
   zx14 = {18'b0, insn[IMM14_MSB:IMM14_LSB]};
   zx18 = {14'b0, insn[IMM18_MSB:IMM18_LSB]};
   e    = '0;
   e.cmd.lu.op_and     = (op inside {OP_AND, OP_AND_I});
   e.cmd.lu.op_or      = (op inside {OP_OR, OP_OR_I});
   e.cmd.lu.op_xor     = (op inside {OP_XOR, OP_XOR_I});
   e.cmd.lu.op_lsl     = (op inside {OP_LSL, OP_LSL_I});
   e.cmd.lu.op_lsr     = (op inside {OP_LSR, OP_LSR_I});
   e.cmd.lu.op_asr     = (op inside {OP_ASR, OP_ASR_I});
   e.cmd.au.op_cmp     = (op == OP_CMP);
   e.cmd.au.op_add     = (op inside {OP_ADD, OP_ADD_I});
   e.cmd.au.op_sub     = (op == OP_SUB);
   e.cmd.au.op_mhi     = (op == OP_MHI);
   e.cmd.au.cmp_eq     = e.cmd.au.op_cmp && (insn[ATTR_MSB:ATTR_LSB] == ATTR_EQ);
   e.cmd.au.cmp_signed = e.cmd.au.op_cmp && (insn[ATTR_MSB:ATTR_LSB] == ATTR_GT);
   e.cmd.mu.load       = (op inside {OP_LDB, OP_LDBU, OP_LDH, OP_LDHU, OP_LDWU});
   e.cmd.mu.store      = (op inside {OP_STB, OP_STH, OP_STW});
   e.cmd.mu.barr       = (op == OP_MBARR);
   e.cmd.mu.sign_ext   = (op inside {OP_LDB, OP_LDH});
   case (op)
      OP_LDB, OP_LDBU: e.cmd.mu.load_size = SIZE_B;
      OP_LDH, OP_LDHU: e.cmd.mu.load_size = SIZE_H;
      OP_LDWU:         e.cmd.mu.load_size = SIZE_W;
      OP_STB:          e.cmd.mu.store_size = SIZE_B;
      OP_STH:          e.cmd.mu.store_size = SIZE_H;
      OP_STW:          e.cmd.mu.store_size = SIZE_W;
      default:         ;
   endcase
   // Nothing decoded means the opcode goes to emulation
   e.cmd.emu_insn    = ~(|{e.cmd.lu, e.cmd.au, e.cmd.mu.load, e.cmd.mu.store, e.cmd.mu.barr});
   e.cmd.wb_regf     = ~(e.cmd.mu.barr | e.cmd.au.op_cmp | e.cmd.mu.store | e.cmd.emu_insn);
   e.cmd.wb_reg_addr = insn[RD_LSB +: NCPU_REG_AW];
   imm_s    = (op inside {OP_AND_I, OP_XOR_I, OP_ADD_I}) || e.cmd.mu.load || e.cmd.mu.store;
   imm_u    = (op inside {OP_OR_I, OP_LSL_I, OP_LSR_I, OP_ASR_I});
   no_rs1   = e.cmd.mu.barr || e.cmd.au.op_mhi;
   e.rs1_re = ~no_rs1;
   e.rs2_re = ~no_rs1 & (e.cmd.mu.store | ~(imm_s | imm_u));
   // Stores read rd through the second port
   e.rs1_addr = insn[RS1_LSB +: NCPU_REG_AW];
   e.rs2_addr = e.cmd.mu.store ? insn[RD_LSB +: NCPU_REG_AW] : insn[RS2_LSB +: NCPU_REG_AW];
   e.op1 = e.cmd.mu.barr ? '0 : e.cmd.au.op_mhi ? zx18 : reg_value(insn[RS1_LSB +: NCPU_REG_AW]);
   e.op2 = e.cmd.mu.barr ? '0 : e.cmd.au.op_mhi ? zx18 : imm_s ? sx14 : imm_u ? zx14
         : reg_value(insn[RS2_LSB +: NCPU_REG_AW]);
   e.op3 = e.cmd.mu.store ? reg_value(insn[RD_LSB +: NCPU_REG_AW]) : '0;
   if (flush) begin
      e.cmd.emu_insn    = 1'b0;
      e.cmd.wb_regf     = 1'b0;
      e.cmd.mu.load     = 1'b0;
      e.cmd.mu.store    = 1'b0;
      e.cmd.mu.barr     = 1'b0;
      e.cmd.mu.sign_ext = 1'b0;
   end
   return e;
endfunction

`endif

/* tb_ncpu_idu.sv */
// Testbench for the decode stage
//   clock, reset, register file model and directed plus random stimulus
//   scoreboard of expected items, stall stability and reset checks
`timescale 1ns/10ps
`default_nettype none

module tb_ncpu_idu;
   import ncpu_idu_pkg::*;
   `include "tb_ncpu_idu_ref.svh"

   localparam int WAIT_LIMIT = 200;

   logic clk;
   logic rst_i;
   logic idu_valid_i;
   logic idu_ready_o;
   logic [NCPU_IW-1:0] insn_i;
   logic flush_i;
   logic regf_rs1_re_o;
   logic [NCPU_REG_AW-1:0] regf_rs1_addr_o;
   logic [NCPU_DW-1:0] regf_rs1_dout_i;
   logic regf_rs2_re_o;
   logic [NCPU_REG_AW-1:0] regf_rs2_addr_o;
   logic [NCPU_DW-1:0] regf_rs2_dout_i;
   logic ieu_valid_o;
   logic ieu_ready_i;
   ieu_cmd_t ieu_cmd_o;
   logic [NCPU_DW-1:0] ieu_operand_1_o;
   logic [NCPU_DW-1:0] ieu_operand_2_o;
   logic [NCPU_DW-1:0] ieu_operand_3_o;

   integer seed;
   logic bp_on;
   logic was_held;
   logic [$bits(ieu_cmd_t)+96:0] held_vec;
   exp_item_t exp_q[$];

   ncpu_idu UUT (.*);

   always #4 clk = ~clk;

   // Register file, data shows up the cycle after the read enable
   always @(posedge clk) begin
      if (regf_rs1_re_o) regf_rs1_dout_i <= reg_value(regf_rs1_addr_o);
      if (regf_rs2_re_o) regf_rs2_dout_i <= reg_value(regf_rs2_addr_o);
   end

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         fail_now($sformatf("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp));
      end
   endtask

   always @(posedge clk) begin : scoreboard
      exp_item_t e;
      logic [$bits(ieu_cmd_t)+96:0] now_vec;
      if (!rst_i) begin
         now_vec = {ieu_valid_o, ieu_cmd_o, ieu_operand_1_o, ieu_operand_2_o, ieu_operand_3_o};
         if (was_held) begin
            assert (now_vec === held_vec)
               else fail_now("Execute outputs changed while the execute unit stalled");
         end
         was_held = ieu_valid_o && !ieu_ready_i;
         held_vec = now_vec;
         if (idu_valid_i && idu_ready_o) begin
            e = expected_item(insn_i, flush_i);
            check_value("regf_rs1_re_o", 32'(regf_rs1_re_o), 32'(e.rs1_re));
            check_value("regf_rs2_re_o", 32'(regf_rs2_re_o), 32'(e.rs2_re));
            if (e.rs1_re) begin
               check_value("regf_rs1_addr_o", 32'(regf_rs1_addr_o), 32'(e.rs1_addr));
            end
            if (e.rs2_re) begin
               check_value("regf_rs2_addr_o", 32'(regf_rs2_addr_o), 32'(e.rs2_addr));
            end
            exp_q.push_back(e);
         end
         if (ieu_valid_o && ieu_ready_i) begin
            assert (exp_q.size() != 0)
               else fail_now("Command left the stage with no accepted instruction behind it");
            e = exp_q.pop_front();
            check_value("ieu_cmd_o.lu", 32'(ieu_cmd_o.lu), 32'(e.cmd.lu));
            check_value("ieu_cmd_o.au", 32'(ieu_cmd_o.au), 32'(e.cmd.au));
            check_value("ieu_cmd_o.mu", 32'(ieu_cmd_o.mu), 32'(e.cmd.mu));
            check_value("ieu_cmd_o.emu_insn", 32'(ieu_cmd_o.emu_insn), 32'(e.cmd.emu_insn));
            check_value("ieu_cmd_o.wb_regf", 32'(ieu_cmd_o.wb_regf), 32'(e.cmd.wb_regf));
            check_value("ieu_cmd_o.wb_reg_addr", 32'(ieu_cmd_o.wb_reg_addr),
                        32'(e.cmd.wb_reg_addr));
            check_value("ieu_operand_1_o", ieu_operand_1_o, e.op1);
            check_value("ieu_operand_2_o", ieu_operand_2_o, e.op2);
            check_value("ieu_operand_3_o", ieu_operand_3_o, e.op3);
         end
      end
   end

   // Random back-pressure is drawn here so all draws stay in one process
   task automatic next_negedge();
      @(negedge clk);
      if (bp_on) ieu_ready_i = ($random(seed) & 3) != 0;
   endtask

   task automatic send_insn(input logic [NCPU_IW-1:0] insn, input logic flush);
      int waited;
      logic taken;
      waited = 0;
      taken = 1'b0;
      idu_valid_i = 1'b1;
      insn_i = insn;
      flush_i = flush;
      while (!taken) begin
         @(posedge clk);
         taken = idu_ready_o;
         next_negedge();
         waited++;
         if (!taken && waited > WAIT_LIMIT) fail_now("Timeout: instruction never accepted");
      end
      idu_valid_i = 1'b0;
      flush_i = 1'b0;
   endtask

   initial begin
      logic [NCPU_IW-1:0] insn;
      logic [31:0] pick;
      int waited;
      int gap;
      seed = 32'h8b598dd8;
      clk = 1'b0;
      rst_i = 1'b1;
      idu_valid_i = 1'b0;
      insn_i = '0;
      flush_i = 1'b0;
      ieu_ready_i = 1'b0;
      regf_rs1_dout_i = '0;
      regf_rs2_dout_i = '0;
      bp_on = 1'b0;
      was_held = 1'b0;
      held_vec = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
      check_value("ieu_valid_o", 32'(ieu_valid_o), 32'd0);
      check_value("idu_ready_o", 32'(idu_ready_o), 32'd1);
      check_value("regf_re", 32'({regf_rs1_re_o, regf_rs2_re_o}), 32'd0);
      check_value("ieu_cmd_o control bits", 32'({ieu_cmd_o.emu_insn, ieu_cmd_o.wb_regf,
                  ieu_cmd_o.mu.load, ieu_cmd_o.mu.store, ieu_cmd_o.mu.barr,
                  ieu_cmd_o.mu.sign_ext}), 32'd0);
      ieu_ready_i = 1'b1;
      // Every opcode value, kept and emulated
      for (int op = 0; op < 64; op++) begin
         insn = $random(seed);
         insn[OPC_MSB:OPC_LSB] = op[5:0];
         send_insn(insn, 1'b0);
      end
      insn = $random(seed);
      insn[OPC_MSB:OPC_LSB] = OP_CMP;
      insn[ATTR_MSB:ATTR_LSB] = ATTR_EQ;
      send_insn(insn, 1'b0);
      insn[ATTR_MSB:ATTR_LSB] = ATTR_GT;
      send_insn(insn, 1'b0);
      insn[OPC_MSB:OPC_LSB] = OP_STW;
      send_insn(insn, 1'b1);
      insn[OPC_MSB:OPC_LSB] = OP_LDB;
      send_insn(insn, 1'b1);
      // Random traffic with stalls, gaps and flushes
      bp_on = 1'b1;
      for (int n = 0; n < 400; n++) begin
         insn = $random(seed);
         pick = {$random(seed)} % 29;
         insn[OPC_MSB:OPC_LSB] = pick[5:0];
         pick = {$random(seed)} % 5;
         send_insn(insn, pick == 0);
         gap = $random(seed) & 3;
         repeat (gap) next_negedge();
      end
      bp_on = 1'b0;
      ieu_ready_i = 1'b1;
      waited = 0;
      while (exp_q.size() != 0) begin
         next_negedge();
         waited++;
         if (waited > WAIT_LIMIT) fail_now("Timeout: items still pending in the stage");
      end
      next_negedge();
      if (exp_q.size() != 0 || ieu_valid_o) begin
         fail_now("Stage still holds an item after draining");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
